//--- all.f
+incdir+hdl
hdl/mmu_pkg.sv
hdl/tlb_cmd_decode.sv
hdl/tlb_execute.sv
hdl/tlb_result.sv
hdl/mmu_top.sv
bench/tb_mmu_top.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal -j 0
TOP       = tb_mmu_top
FILELIST  = all.f
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = Regression failed
PASS_MSG  = Regression passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation ended without a verdict"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- bench/tb_mmu_top.sv
`include "mmu_cfg.svh"

module tb_mmu_top;
    timeunit 1ns;
    timeprecision 1ps;

    import mmu_pkg::*;

    localparam int TLBNUM      = `MMU_TLBNUM;
    localparam int NUM_CMDS    = 16 * 5 + 600;
    localparam int CYCLE_LIMIT = 2 * NUM_CMDS + 50;

    logic        clk;
    logic        reset;
    logic        cmd_valid;
    cmd_op_e     cmd_op;
    cp0_sel_e    cmd_sel;
    logic        cmd_store;
    logic [31:0] cmd_addr;
    logic [31:0] cmd_wdata;
    logic        result_valid;
    logic [31:0] result_data;
    tlb_exc_e    result_exc;

    integer seed;
    int     cycle = 0;
    int     mismatch_errors = 0;
    int     other_errors = 0;

    // reference state, EntryHi kept in register format
    logic [31:0] m_hi [TLBNUM];
    logic [25:0] m_lo0 [TLBNUM];
    logic [25:0] m_lo1 [TLBNUM];
    logic        m_g [TLBNUM];
    logic [31:0] m_entryhi;
    logic [25:0] m_entrylo0;
    logic [25:0] m_entrylo1;
    logic        m_index_p;
    int          m_index_val;

    logic [31:0] exp_data_q [$];
    logic [2:0]  exp_exc_q [$];
    int          exp_cycle_q [$];
    logic [31:0] want_data;
    logic [2:0]  want_exc;
    int          want_cycle;

    mmu_top UUT (
        .clk          (clk),
        .reset        (reset),
        .cmd_valid    (cmd_valid),
        .cmd_op       (cmd_op),
        .cmd_sel      (cmd_sel),
        .cmd_store    (cmd_store),
        .cmd_addr     (cmd_addr),
        .cmd_wdata    (cmd_wdata),
        .result_valid (result_valid),
        .result_data  (result_data),
        .result_exc   (result_exc)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= CYCLE_LIMIT) begin
            $display("timeout: run still going after %0d cycles", cycle);
            $display("Regression failed");
            $finish;
        end
    end

    function automatic int unsigned pick(int unsigned n);
        pick = $unsigned($random(seed)) % n;
    endfunction

    // small pools so hits, misses and aliases all occur
    function automatic logic [18:0] pool_vpn2(int unsigned k);
        pool_vpn2 = 19'h2A5C0 + 19'(k);
    endfunction

    function automatic logic [7:0] pool_asid(int unsigned k);
        pool_asid = 8'h40 + 8'(k);
    endfunction

    // mostly valid pages, garbage in the unused upper bits
    function automatic logic [31:0] random_lo();
        logic [31:0] w;
        w = $random(seed);
        w[1] = (pick(4) != 0);
        random_lo = w;
    endfunction

    function automatic int lookup(logic [18:0] vpn2, logic [7:0] asid);
        lookup = -1;
        for (int i = 0; i < TLBNUM; i++) begin
            if (lookup < 0 && m_hi[i][31:13] == vpn2 && (m_g[i] || m_hi[i][7:0] == asid)) begin
                lookup = i;
            end
        end
    endfunction

    task automatic predict(input logic [2:0] op, input logic [1:0] sel, input logic store,
                           input logic [31:0] addr, input logic [31:0] wdata);
        int          idx;
        logic [25:0] lo;
        logic [31:0] data;
        logic [2:0]  exc;
        data = '0;
        exc  = EXC_NONE;
        case (op)
            OP_TRANSLATE: begin
                idx = lookup(addr[31:13], m_entryhi[7:0]);
                if (idx < 0) begin
                    exc = store ? EXC_TLBS_REFILL : EXC_TLBL_REFILL;
                end else begin
                    lo = addr[12] ? m_lo1[idx] : m_lo0[idx];
                    if (!lo[1])
                        exc = store ? EXC_TLBS_INVALID : EXC_TLBL_INVALID;
                    else if (store && !lo[2])
                        exc = EXC_MOD;
                    else
                        data = {lo[25:6], addr[11:0]};
                end
            end
            OP_PROBE: begin
                idx = lookup(m_entryhi[31:13], m_entryhi[7:0]);
                m_index_p   = (idx < 0);
                m_index_val = (idx < 0) ? 0 : idx;
                data = {m_index_p, 31'(m_index_val)};
            end
            OP_TLBR: begin
                m_entryhi  = m_hi[m_index_val];
                m_entrylo0 = {m_lo0[m_index_val][25:1], m_g[m_index_val]};
                m_entrylo1 = {m_lo1[m_index_val][25:1], m_g[m_index_val]};
            end
            OP_TLBWI: begin
                m_hi[m_index_val]  = m_entryhi;
                m_lo0[m_index_val] = m_entrylo0;
                m_lo1[m_index_val] = m_entrylo1;
                m_g[m_index_val]   = m_entrylo0[0] & m_entrylo1[0];
            end
            OP_MTC0: begin
                case (sel)
                    2'd0: m_entryhi = wdata & 32'hFFFF_E0FF;
                    2'd1: m_entrylo0 = wdata[25:0];
                    2'd2: m_entrylo1 = wdata[25:0];
                    default: begin
                        m_index_p   = 1'b0;
                        m_index_val = wdata & (TLBNUM - 1);
                    end
                endcase
            end
            OP_MFC0: begin
                case (sel)
                    2'd0: data = m_entryhi;
                    2'd1: data = {6'd0, m_entrylo0};
                    2'd2: data = {6'd0, m_entrylo1};
                    default: data = {m_index_p, 31'(m_index_val)};
                endcase
            end
            default: exc = EXC_BAD_CMD;
        endcase
        exp_data_q.push_back(data);
        exp_exc_q.push_back(exc);
        exp_cycle_q.push_back(cycle);
    endtask

    task automatic issue(input logic [2:0] op, input logic [1:0] sel, input logic store,
                         input logic [31:0] addr, input logic [31:0] wdata);
        @(negedge clk);
        cmd_valid = 1'b1;
        cmd_op    = cmd_op_e'(op);
        cmd_sel   = cp0_sel_e'(sel);
        cmd_store = store;
        cmd_addr  = addr;
        cmd_wdata = wdata;
        predict(op, sel, store, addr, wdata);
    endtask

    // other inputs wiggle while valid is low
    task automatic idle_cycle();
        @(negedge clk);
        cmd_valid = 1'b0;
        cmd_op    = cmd_op_e'(pick(8));
        cmd_store = 1'(pick(2));
        cmd_addr  = $random(seed);
        cmd_wdata = $random(seed);
    endtask

    // sampled one edge after issue, result two edges later
    always @(negedge clk) begin
        if (!reset && result_valid) begin
            if (exp_data_q.size() == 0) begin
                $display("result_valid at %0d ns with no command outstanding", $time);
                other_errors++;
            end else begin
                want_data  = exp_data_q.pop_front();
                want_exc   = exp_exc_q.pop_front();
                want_cycle = exp_cycle_q.pop_front();
                if (result_data !== want_data) begin
                    $display("mismatch at %0d ns: result_data expected %h got %h",
                             $time, want_data, result_data);
                    mismatch_errors++;
                end
                if (result_exc !== want_exc) begin
                    $display("mismatch at %0d ns: result_exc expected %0d got %0d",
                             $time, want_exc, result_exc);
                    mismatch_errors++;
                end
                if (cycle - want_cycle != 3) begin
                    $display("mismatch at %0d ns: result_valid cycle expected %0d got %0d",
                             $time, want_cycle + 3, cycle);
                    mismatch_errors++;
                end
            end
        end
    end

    initial begin
        int          kind;
        logic [2:0]  op;
        logic [1:0]  sel;
        logic        store;
        logic [31:0] addr;
        logic [31:0] wdata;
        seed      = 77;
        cmd_valid = 1'b0;
        cmd_op    = OP_TRANSLATE;
        cmd_sel   = SEL_ENTRYHI;
        cmd_store = 1'b0;
        cmd_addr  = '0;
        cmd_wdata = '0;
        reset     = 1'b1;
        for (int i = 0; i < TLBNUM; i++) begin
            m_hi[i]  = '0;
            m_lo0[i] = '0;
            m_lo1[i] = '0;
            m_g[i]   = 1'b0;
        end
        m_entryhi   = '0;
        m_entrylo0  = '0;
        m_entrylo1  = '0;
        m_index_p   = 1'b0;
        m_index_val = 0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // fill the TLB, entries i and i+8 share a page pair
        for (int i = 0; i < 16; i++) begin
            issue(OP_MTC0, SEL_INDEX, 1'b0, '0, i);
            issue(OP_MTC0, SEL_ENTRYHI, 1'b0, '0,
                  {pool_vpn2(i % 8), 5'd0, pool_asid(pick(3))});
            issue(OP_MTC0, SEL_ENTRYLO0, 1'b0, '0, random_lo());
            issue(OP_MTC0, SEL_ENTRYLO1, 1'b0, '0, random_lo());
            issue(OP_TLBWI, SEL_ENTRYHI, 1'b0, '0, '0);
        end

        for (int n = 0; n < 600; n++) begin
            kind  = pick(16);
            sel   = 2'(pick(4));
            store = 1'(pick(2));
            addr  = $random(seed);
            wdata = $random(seed);
            if (kind < 8) begin
                op   = OP_TRANSLATE;
                addr = {pool_vpn2(pick(10)), addr[12:0]};
            end else if (kind == 8) begin
                op = OP_PROBE;
            end else if (kind == 9) begin
                op = OP_TLBR;
            end else if (kind == 10) begin
                op = OP_TLBWI;
            end else if (kind < 13) begin
                op = OP_MTC0;
                if (sel == 2'd0)
                    wdata = {pool_vpn2(pick(10)), wdata[12:8], pool_asid(pick(3))};
                else if (sel != 2'd3)
                    wdata = random_lo();
            end else if (kind < 15) begin
                op = OP_MFC0;
            end else begin
                op = 3'(6 + pick(2));
            end
            issue(op, sel, store, addr, wdata);
            if (pick(4) == 0)
                idle_cycle();
        end
        idle_cycle();

        for (int k = 0; k < 10 && exp_data_q.size() != 0; k++) begin
            @(negedge clk);
        end
        repeat (3) @(negedge clk);
        if (exp_data_q.size() != 0) begin
            $display("%0d expected results never arrived", exp_data_q.size());
            other_errors++;
        end

        $display("errors: %0d mismatches, %0d other", mismatch_errors, other_errors);
        if (mismatch_errors + other_errors == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

//--- hdl/mmu_top.sv
`include "mmu_cfg.svh"

module mmu_top (
    input  logic              clk,
    input  logic              reset,
    input  logic              cmd_valid,
    input  mmu_pkg::cmd_op_e  cmd_op,
    input  mmu_pkg::cp0_sel_e cmd_sel,
    input  logic              cmd_store,
    input  logic [31:0]       cmd_addr,
    input  logic [31:0]       cmd_wdata,
    output logic              result_valid,
    output logic [31:0]       result_data,
    output mmu_pkg::tlb_exc_e result_exc
);
    import mmu_pkg::*;

    // decode to execute
    logic        d_valid;
    cmd_op_e     d_op;
    cp0_sel_e    d_sel;
    logic        d_store;
    logic [31:0] d_addr;
    logic [31:0] d_wdata;
    logic        d_bad;

    // execute to result
    logic                    x_valid;
    cmd_op_e                 x_op;
    logic                    x_store;
    logic                    x_bad;
    logic [`MMU_OFFSET_WD:0] x_addr_low;
    logic                    x_hit;
    logic                    x_v;
    logic                    x_d;
    logic [`MMU_PFN_WD-1:0]  x_pfn;
    logic [31:0]             x_data;

    tlb_cmd_decode u_decode (
        .clk       (clk),
        .reset     (reset),
        .cmd_valid (cmd_valid),
        .cmd_op    (cmd_op),
        .cmd_sel   (cmd_sel),
        .cmd_store (cmd_store),
        .cmd_addr  (cmd_addr),
        .cmd_wdata (cmd_wdata),
        .d_valid   (d_valid),
        .d_op      (d_op),
        .d_sel     (d_sel),
        .d_store   (d_store),
        .d_addr    (d_addr),
        .d_wdata   (d_wdata),
        .d_bad     (d_bad)
    );

    tlb_execute #(
        .TLBNUM (`MMU_TLBNUM)
    ) u_execute (
        .clk        (clk),
        .reset      (reset),
        .d_valid    (d_valid),
        .d_op       (d_op),
        .d_sel      (d_sel),
        .d_store    (d_store),
        .d_addr     (d_addr),
        .d_wdata    (d_wdata),
        .d_bad      (d_bad),
        .x_valid    (x_valid),
        .x_op       (x_op),
        .x_store    (x_store),
        .x_bad      (x_bad),
        .x_addr_low (x_addr_low),
        .x_hit      (x_hit),
        .x_v        (x_v),
        .x_d        (x_d),
        .x_pfn      (x_pfn),
        .x_data     (x_data)
    );

    tlb_result u_result (
        .clk          (clk),
        .reset        (reset),
        .x_valid      (x_valid),
        .x_op         (x_op),
        .x_store      (x_store),
        .x_bad        (x_bad),
        .x_addr_low   (x_addr_low),
        .x_hit        (x_hit),
        .x_v          (x_v),
        .x_d          (x_d),
        .x_pfn        (x_pfn),
        .x_data       (x_data),
        .result_valid (result_valid),
        .result_data  (result_data),
        .result_exc   (result_exc)
    );

endmodule

//--- hdl/tlb_result.sv
`include "mmu_cfg.svh"

module tlb_result (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    x_valid,
    input  mmu_pkg::cmd_op_e        x_op,
    input  logic                    x_store,
    input  logic                    x_bad,
    input  logic [`MMU_OFFSET_WD:0] x_addr_low,
    input  logic                    x_hit,
    input  logic                    x_v,
    input  logic                    x_d,
    input  logic [`MMU_PFN_WD-1:0]  x_pfn,
    input  logic [31:0]             x_data,
    output logic                    result_valid,
    output logic [31:0]             result_data,
    output mmu_pkg::tlb_exc_e       result_exc
);
    import mmu_pkg::*;

    tlb_exc_e    exc;
    logic [31:0] paddr;
    logic [31:0] data;

    assign paddr = {x_pfn, x_addr_low[`MMU_OFFSET_WD-1:0]};

    // refill beats invalid beats modified
    always_comb begin
        if (x_bad) begin
            exc = EXC_BAD_CMD;
        end else if (x_op != OP_TRANSLATE) begin
            exc = EXC_NONE;
        end else if (!x_hit) begin
            exc = x_store ? EXC_TLBS_REFILL : EXC_TLBL_REFILL;
        end else if (!x_v) begin
            exc = x_store ? EXC_TLBS_INVALID : EXC_TLBL_INVALID;
        end else if (x_store && !x_d) begin
            exc = EXC_MOD;
        end else begin
            exc = EXC_NONE;
        end
    end

    always_comb begin
        data = '0;
        if (!x_bad) begin
            case (x_op)
                OP_TRANSLATE: data = (exc == EXC_NONE) ? paddr : '0;
                OP_PROBE:     data = x_data;
                OP_MFC0:      data = x_data;
                default:      data = '0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= x_valid;
        end
    end

    always_ff @(posedge clk) begin
        result_data <= data;
        result_exc  <= exc;
    end

endmodule

//--- hdl/tlb_execute.sv
`include "mmu_cfg.svh"

module tlb_execute #(
    parameter int TLBNUM = `MMU_TLBNUM
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    d_valid,
    input  mmu_pkg::cmd_op_e        d_op,
    input  mmu_pkg::cp0_sel_e       d_sel,
    input  logic                    d_store,
    input  logic [31:0]             d_addr,
    input  logic [31:0]             d_wdata,
    input  logic                    d_bad,
    output logic                    x_valid,
    output mmu_pkg::cmd_op_e        x_op,
    output logic                    x_store,
    output logic                    x_bad,
    output logic [`MMU_OFFSET_WD:0] x_addr_low,
    output logic                    x_hit,
    output logic                    x_v,
    output logic                    x_d,
    output logic [`MMU_PFN_WD-1:0]  x_pfn,
    output logic [31:0]             x_data
);
    import mmu_pkg::*;

    localparam int IDX_WD = $clog2(TLBNUM);
    localparam int LO_WD  = `MMU_PFN_WD + 6;

    tlb_entry_t tlb [TLBNUM];

    logic [`MMU_VPN2_WD-1:0] entryhi_vpn2;
    logic [`MMU_ASID_WD-1:0] entryhi_asid;
    logic [LO_WD-1:0]        entrylo0;
    logic [LO_WD-1:0]        entrylo1;
    logic                    index_p;
    logic [IDX_WD-1:0]       index_val;

    logic                    is_probe;
    logic [`MMU_VPN2_WD-1:0] s_vpn2;
    logic                    s_odd;
    logic                    s_hit;
    logic [IDX_WD-1:0]       s_idx;
    tlb_entry_t              s_ent;
    tlb_entry_t              r_ent;
    tlb_entry_t              w_ent;
    logic [31:0]             probe_word;
    logic [31:0]             mfc0_word;
    logic                    do_cmd;

    // probe keys on EntryHi and the even page, translate on the address
    assign is_probe = (d_op == OP_PROBE);
    assign s_vpn2   = is_probe ? entryhi_vpn2 : d_addr[31 -: `MMU_VPN2_WD];
    assign s_odd    = is_probe ? 1'b0 : d_addr[`MMU_OFFSET_WD];
    assign do_cmd   = d_valid && !d_bad;

    // walk downward so the lowest matching index is the one kept
    // s_idx stays zero on a miss
    always_comb begin
        s_hit = 1'b0;
        s_idx = '0;
        for (int i = TLBNUM - 1; i >= 0; i--) begin
            if (tlb[i].vpn2 == s_vpn2 && (tlb[i].g || tlb[i].asid == entryhi_asid)) begin
                s_hit = 1'b1;
                s_idx = IDX_WD'(i);
            end
        end
    end

    assign s_ent = tlb[s_idx];
    assign r_ent = tlb[index_val];

    always_comb begin
        w_ent      = '0;
        w_ent.vpn2 = entryhi_vpn2;
        w_ent.asid = entryhi_asid;
        w_ent.g    = entrylo0[0] & entrylo1[0];
        {w_ent.pfn0, w_ent.c0, w_ent.d0, w_ent.v0} = entrylo0[LO_WD-1:1];
        {w_ent.pfn1, w_ent.c1, w_ent.d1, w_ent.v1} = entrylo1[LO_WD-1:1];
    end

    assign probe_word = {!s_hit, {(31 - IDX_WD){1'b0}}, s_idx};

    always_comb begin
        case (d_sel)
            SEL_ENTRYHI: begin
                mfc0_word = {entryhi_vpn2, {(32 - `MMU_VPN2_WD - `MMU_ASID_WD){1'b0}},
                             entryhi_asid};
            end
            SEL_ENTRYLO0: mfc0_word = {{(32 - LO_WD){1'b0}}, entrylo0};
            SEL_ENTRYLO1: mfc0_word = {{(32 - LO_WD){1'b0}}, entrylo1};
            default:      mfc0_word = {index_p, {(31 - IDX_WD){1'b0}}, index_val};
        endcase
    end

    // every architectural update lands here, one command per cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < TLBNUM; i++) begin
                tlb[i] <= '0;
            end
            entryhi_vpn2 <= '0;
            entryhi_asid <= '0;
            entrylo0     <= '0;
            entrylo1     <= '0;
            index_p      <= 1'b0;
            index_val    <= '0;
        end else if (do_cmd) begin
            case (d_op)
                OP_PROBE: begin
                    index_p   <= !s_hit;
                    index_val <= s_idx;
                end
                OP_TLBR: begin
                    entryhi_vpn2 <= r_ent.vpn2;
                    entryhi_asid <= r_ent.asid;
                    entrylo0     <= {r_ent.pfn0, r_ent.c0, r_ent.d0, r_ent.v0, r_ent.g};
                    entrylo1     <= {r_ent.pfn1, r_ent.c1, r_ent.d1, r_ent.v1, r_ent.g};
                end
                OP_TLBWI: begin
                    tlb[index_val] <= w_ent;
                end
                OP_MTC0: begin
                    case (d_sel)
                        SEL_ENTRYHI: begin
                            entryhi_vpn2 <= d_wdata[31 -: `MMU_VPN2_WD];
                            entryhi_asid <= d_wdata[`MMU_ASID_WD-1:0];
                        end
                        SEL_ENTRYLO0: entrylo0 <= d_wdata[LO_WD-1:0];
                        SEL_ENTRYLO1: entrylo1 <= d_wdata[LO_WD-1:0];
                        default: begin
                            index_p   <= 1'b0;
                            index_val <= d_wdata[IDX_WD-1:0];
                        end
                    endcase
                end
                default: begin
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            x_valid <= 1'b0;
        end else begin
            x_valid <= d_valid;
        end
    end

    always_ff @(posedge clk) begin
        x_op       <= d_op;
        x_store    <= d_store;
        x_bad      <= d_bad;
        x_addr_low <= d_addr[`MMU_OFFSET_WD:0];
        x_hit      <= s_hit;
        x_v        <= s_odd ? s_ent.v1 : s_ent.v0;
        x_d        <= s_odd ? s_ent.d1 : s_ent.d0;
        x_pfn      <= s_odd ? s_ent.pfn1 : s_ent.pfn0;
        x_data     <= is_probe ? probe_word : mfc0_word;
    end

endmodule

//--- hdl/tlb_cmd_decode.sv
`include "mmu_cfg.svh"

module tlb_cmd_decode (
    input  logic               clk,
    input  logic               reset,
    input  logic               cmd_valid,
    input  mmu_pkg::cmd_op_e   cmd_op,
    input  mmu_pkg::cp0_sel_e  cmd_sel,
    input  logic               cmd_store,
    input  logic [31:0]        cmd_addr,
    input  logic [31:0]        cmd_wdata,
    output logic               d_valid,
    output mmu_pkg::cmd_op_e   d_op,
    output mmu_pkg::cp0_sel_e  d_sel,
    output logic               d_store,
    output logic [31:0]        d_addr,
    output logic [31:0]        d_wdata,
    output logic               d_bad
);
    import mmu_pkg::*;

    logic op_legal;
    logic is_translate;

    // codes 6 and 7 have no operation behind them
    assign op_legal = cmd_op inside {OP_TRANSLATE, OP_PROBE, OP_TLBR,
                                     OP_TLBWI, OP_MTC0, OP_MFC0};
    assign is_translate = (cmd_op == OP_TRANSLATE);

    always_ff @(posedge clk) begin
        if (reset) begin
            d_valid <= 1'b0;
        end else begin
            d_valid <= cmd_valid;
        end
    end

    always_ff @(posedge clk) begin
        d_op    <= cmd_op;
        d_sel   <= cmd_sel;
        d_addr  <= cmd_addr;
        d_wdata <= cmd_wdata;
        d_bad   <= !op_legal;
        // store only means something for a translation
        d_store <= cmd_store && is_translate;
    end

endmodule

//--- hdl/mmu_pkg.sv
`include "mmu_cfg.svh"

package mmu_pkg;

    typedef enum logic [2:0] {
        OP_TRANSLATE = 3'd0,
        OP_PROBE     = 3'd1,
        OP_TLBR      = 3'd2,
        OP_TLBWI     = 3'd3,
        OP_MTC0      = 3'd4,
        OP_MFC0      = 3'd5
    } cmd_op_e;

    typedef enum logic [1:0] {
        SEL_ENTRYHI  = 2'd0,
        SEL_ENTRYLO0 = 2'd1,
        SEL_ENTRYLO1 = 2'd2,
        SEL_INDEX    = 2'd3
    } cp0_sel_e;

    typedef enum logic [2:0] {
        EXC_NONE         = 3'd0,
        EXC_TLBL_REFILL  = 3'd1,
        EXC_TLBS_REFILL  = 3'd2,
        EXC_TLBL_INVALID = 3'd3,
        EXC_TLBS_INVALID = 3'd4,
        EXC_MOD          = 3'd5,
        EXC_BAD_CMD      = 3'd6
    } tlb_exc_e;

    // one entry maps an even/odd page pair
    typedef struct packed {
        logic [`MMU_VPN2_WD-1:0] vpn2;
        logic [`MMU_ASID_WD-1:0] asid;
        logic                    g;
        logic [`MMU_PFN_WD-1:0]  pfn0;
        logic [2:0]              c0;
        logic                    d0;
        logic                    v0;
        logic [`MMU_PFN_WD-1:0]  pfn1;
        logic [2:0]              c1;
        logic                    d1;
        logic                    v1;
    } tlb_entry_t;

endpackage

//--- hdl/mmu_cfg.svh
`ifndef MMU_CFG_SVH
`define MMU_CFG_SVH

// number of TLB entries, power of two
`define MMU_TLBNUM 16

// 4 KB pages, bit 12 picks the odd page of a pair
`define MMU_OFFSET_WD 12

// address space id carried in EntryHi
`define MMU_ASID_WD 8

// virtual page pair number, address bits 31..13
`define MMU_VPN2_WD 19

// physical frame number in EntryLo
`define MMU_PFN_WD 20

`endif
